// File: source/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

	// Field widths of the 32-bit instruction word
	localparam int instrWidth = 32;
	localparam int opcodeWidth = 5;
	localparam int regFieldWidth = 4;
	localparam int constWidth = 19;
	localparam int unusedWidth = instrWidth - opcodeWidth - 3 * regFieldWidth;

	// One IR word read two ways: three-register or register plus constant
	typedef union packed {
		struct packed {
			logic [opcodeWidth-1:0]   opcode;
			logic [regFieldWidth-1:0] ra;
			logic [regFieldWidth-1:0] rb;
			logic [regFieldWidth-1:0] rc;
			logic [unusedWidth-1:0]   unused;
		} rFmt;
		struct packed {
			logic [opcodeWidth-1:0]   opcode;
			logic [regFieldWidth-1:0] ra;
			logic [regFieldWidth-1:0] rb;
			logic [constWidth-1:0]    c;	// Signed offset or immediate
		} iFmt;
	} instrWord;

endpackage

`default_nettype wire

// File: source/datapathPkg.sv
`default_nettype none

package datapathPkg;

	// Data word and shift amount
	localparam int wordWidth = 32;
	localparam int shiftWidth = $clog2(wordWidth);

	// General register file
	localparam int regCount = 16;

	// Main memory, word addressed
	localparam int ramDepth = 512;
	localparam int ramAddrWidth = $clog2(ramDepth);

endpackage

`default_nettype wire

// File: source/registerFile.sv
`timescale 1ns/100ps
`default_nettype none

module registerFile (
	input  wire logic                               clock,
	input  wire logic                               rstN,
	input  wire cpuIsaPkg::instrWord                instr,
	input  wire logic                               gra,
	input  wire logic                               grb,
	input  wire logic                               grc,
	input  wire logic                               rIn,
	input  wire logic                               baOut,
	input  wire logic [datapathPkg::wordWidth-1:0]  busData,
	output logic      [datapathPkg::wordWidth-1:0]  regData
);
	import cpuIsaPkg::*;
	import datapathPkg::*;

	logic [regFieldWidth-1:0] regSel;
	logic [wordWidth-1:0]     regs [regCount];

	// Register index comes from the IR field named by the select strobe
	always_comb begin
		if (gra) begin
			regSel = instr.rFmt.ra;
		end else if (grb) begin
			regSel = instr.rFmt.rb;
		end else if (grc) begin
			regSel = instr.rFmt.rc;
		end else begin
			regSel = '0;	// No select, default to R0
		end
	end

	// Write port from the bus
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (rIn) begin
			regs[regSel] <= busData;
		end
	end

	// Base-address read: R0 stands for no base register
	always_comb begin
		if (baOut && regSel == '0) begin
			regData = '0;
		end else begin
			regData = regs[regSel];
		end
	end

endmodule

`default_nettype wire

// File: source/aluUnit.sv
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
	input  wire logic [datapathPkg::wordWidth-1:0] yData,
	input  wire logic [datapathPkg::wordWidth-1:0] busData,
	input  wire logic                              incPc,
	input  wire logic                              opAdd,
	input  wire logic                              opSub,
	input  wire logic                              opAnd,
	input  wire logic                              opOr,
	input  wire logic                              opShr,
	input  wire logic                              opShra,
	input  wire logic                              opShl,
	input  wire logic                              opRor,
	input  wire logic                              opRol,
	input  wire logic                              opNeg,
	input  wire logic                              opNot,
	output logic      [datapathPkg::wordWidth-1:0] result
);
	import datapathPkg::*;

	logic [shiftWidth-1:0]  shiftAmt;
	logic [2*wordWidth-1:0] rorWide;
	logic [2*wordWidth-1:0] rolWide;

	assign shiftAmt = busData[shiftWidth-1:0];	// Amount is taken mod 32

	// Rotates from a doubled copy of Y
	assign rorWide = {yData, yData} >> shiftAmt;
	assign rolWide = {yData, yData} << shiftAmt;

	// Fixed priority, PC increment first
	always_comb begin
		if (incPc) begin
			result = busData + wordWidth'(1);
		end else if (opAdd) begin
			result = yData + busData;
		end else if (opSub) begin
			result = yData - busData;
		end else if (opAnd) begin
			result = yData & busData;
		end else if (opOr) begin
			result = yData | busData;
		end else if (opShr) begin
			result = yData >> shiftAmt;
		end else if (opShra) begin
			result = $signed(yData) >>> shiftAmt;	// Keeps the sign bit
		end else if (opShl) begin
			result = yData << shiftAmt;
		end else if (opRor) begin
			result = rorWide[wordWidth-1:0];
		end else if (opRol) begin
			result = rolWide[2*wordWidth-1:wordWidth];
		end else if (opNeg) begin
			result = -busData;
		end else if (opNot) begin
			result = ~busData;
		end else begin
			// Pass the bus through unchanged
			result = busData;
		end
	end

endmodule

`default_nettype wire

// File: source/memorySubsystem.sv
`timescale 1ns/100ps
`default_nettype none

module memorySubsystem (
	input  wire logic                              clock,
	input  wire logic                              rstN,
	input  wire logic [datapathPkg::wordWidth-1:0] busData,
	input  wire logic                              marIn,
	input  wire logic                              mdrIn,
	input  wire logic                              mdMuxRead,
	input  wire logic                              ramRead,
	input  wire logic                              ramWrite,
	output logic      [datapathPkg::wordWidth-1:0] mdrData
);
	import datapathPkg::*;

	logic [wordWidth-1:0]    marReg;
	logic [ramAddrWidth-1:0] ramAddr;
	logic [wordWidth-1:0]    ramRdData;
	logic [wordWidth-1:0]    mdrNext;
	logic [wordWidth-1:0]    ram [ramDepth];

	assign ramAddr = marReg[ramAddrWidth-1:0];	// Upper MAR bits ignored

	// Address register
	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			marReg <= '0;
		end else if (marIn) begin
			marReg <= busData;
		end
	end

	// Asynchronous read, quiet unless enabled and out of reset
	assign ramRdData = (ramRead && rstN) ? ram[ramAddr] : '0;

	// MDR source select
	assign mdrNext = mdMuxRead ? ramRdData : busData;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			mdrData <= '0;
		end else if (mdrIn) begin
			mdrData <= mdrNext;
		end
	end

	// Stores take MDR at the MAR address
	always_ff @(posedge clock) begin
		if (ramWrite) begin
			ram[ramAddr] <= mdrData;
		end
	end

endmodule

`default_nettype wire

// File: source/datapath.sv
`timescale 1ns/100ps
`default_nettype none

module datapath (
	input  wire logic                              clock,
	input  wire logic                              rstN,
	// Bus sources
	input  wire logic                              pcOut,
	input  wire logic                              mdrOut,
	input  wire logic                              zOut,
	input  wire logic                              rOut,
	input  wire logic                              baOut,
	input  wire logic                              cseOut,
	input  wire logic                              inPortOut,
	// Register loads
	input  wire logic                              pcIn,
	input  wire logic                              irIn,
	input  wire logic                              marIn,
	input  wire logic                              mdrIn,
	input  wire logic                              yIn,
	input  wire logic                              zIn,
	input  wire logic                              rIn,
	input  wire logic                              outPortIn,
	// Memory
	input  wire logic                              mdMuxRead,
	input  wire logic                              ramRead,
	input  wire logic                              ramWrite,
	// Register select
	input  wire logic                              gra,
	input  wire logic                              grb,
	input  wire logic                              grc,
	// ALU
	input  wire logic                              incPc,
	input  wire logic                              opAdd,
	input  wire logic                              opSub,
	input  wire logic                              opAnd,
	input  wire logic                              opOr,
	input  wire logic                              opShr,
	input  wire logic                              opShra,
	input  wire logic                              opShl,
	input  wire logic                              opRor,
	input  wire logic                              opRol,
	input  wire logic                              opNeg,
	input  wire logic                              opNot,
	// Ports
	input  wire logic [datapathPkg::wordWidth-1:0] inPortData,
	output logic      [datapathPkg::wordWidth-1:0] outPortData
);
	import cpuIsaPkg::*;
	import datapathPkg::*;

	logic [wordWidth-1:0] busData;
	logic [wordWidth-1:0] pcReg;
	instrWord             irReg;
	logic [wordWidth-1:0] yReg;
	logic [wordWidth-1:0] zReg;
	logic [wordWidth-1:0] cseData;
	logic [wordWidth-1:0] regData;
	logic [wordWidth-1:0] mdrData;
	logic [wordWidth-1:0] aluResult;

	// Constant field sign-extended to a full word
	assign cseData = {{(wordWidth - constWidth){irReg.iFmt.c[constWidth-1]}}, irReg.iFmt.c};

	// One source per cycle, fixed priority if strobes collide
	always_comb begin
		if (pcOut) begin
			busData = pcReg;
		end else if (mdrOut) begin
			busData = mdrData;
		end else if (zOut) begin
			busData = zReg;
		end else if (rOut || baOut) begin
			busData = regData;
		end else if (cseOut) begin
			busData = cseData;
		end else if (inPortOut) begin
			busData = inPortData;
		end else begin
			busData = '0;	// Idle bus
		end
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			pcReg <= '0;
			irReg <= '0;
			yReg <= '0;
			zReg <= '0;
			outPortData <= '0;
		end else begin
			if (pcIn) pcReg <= busData;
			if (irIn) irReg <= busData;
			if (yIn) yReg <= busData;
			if (zIn) zReg <= aluResult;	// Z only ever loads from the ALU
			if (outPortIn) outPortData <= busData;
		end
	end

	registerFile i_registerFile (
		.clock   (clock),
		.rstN    (rstN),
		.instr   (irReg),
		.gra     (gra),
		.grb     (grb),
		.grc     (grc),
		.rIn     (rIn),
		.baOut   (baOut),
		.busData (busData),
		.regData (regData)
	);

	aluUnit i_aluUnit (
		.yData   (yReg),
		.busData (busData),
		.incPc   (incPc),
		.opAdd   (opAdd),
		.opSub   (opSub),
		.opAnd   (opAnd),
		.opOr    (opOr),
		.opShr   (opShr),
		.opShra  (opShra),
		.opShl   (opShl),
		.opRor   (opRor),
		.opRol   (opRol),
		.opNeg   (opNeg),
		.opNot   (opNot),
		.result  (aluResult)
	);

	memorySubsystem i_memorySubsystem (
		.clock     (clock),
		.rstN      (rstN),
		.busData   (busData),
		.marIn     (marIn),
		.mdrIn     (mdrIn),
		.mdMuxRead (mdMuxRead),
		.ramRead   (ramRead),
		.ramWrite  (ramWrite),
		.mdrData   (mdrData)
	);

endmodule

`default_nettype wire

// File: include/datapathModel.svh
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH

// Reference state mirrored step by step alongside the DUT
logic [datapathPkg::wordWidth-1:0] modelRegs [datapathPkg::regCount];
logic [datapathPkg::wordWidth-1:0] modelRam [datapathPkg::ramDepth];
logic [datapathPkg::wordWidth-1:0] modelPc;

// Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsrState = 32'h60db866a;

// One LFSR step per bit with bits collected LSB first
function automatic logic [31:0] lfsrBits(input int unsigned count);
	logic [31:0] bits;
	bits = '0;
	for (int unsigned i = 0; i < count; i++) begin
		bits[i] = lfsrState[0];
		lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
	end
	return bits;
endfunction

// Sign extension of the IR constant field
function automatic logic [datapathPkg::wordWidth-1:0] modelSext(
	input logic [cpuIsaPkg::constWidth-1:0] c
);
	return datapathPkg::wordWidth'($signed(c));
endfunction

// Register read where R0 is zero under base addressing
function automatic logic [datapathPkg::wordWidth-1:0] modelReadReg(
	input logic [cpuIsaPkg::regFieldWidth-1:0] idx,
	input logic                                ba
);
	return (ba && idx == '0) ? '0 : modelRegs[idx];
endfunction

// ALU ops indexed 0 to 10 in the order add sub and or shr shra shl ror rol neg not
function automatic logic [datapathPkg::wordWidth-1:0] modelAlu(
	input int unsigned                       op,
	input logic [datapathPkg::wordWidth-1:0] y,
	input logic [datapathPkg::wordWidth-1:0] b
);
	logic [datapathPkg::shiftWidth-1:0] s;
	logic [datapathPkg::wordWidth-1:0]  ones;
	s = b[datapathPkg::shiftWidth-1:0];
	ones = {datapathPkg::wordWidth{1'b1}};
	case (op)
		0:       return y + b;
		1:       return y - b;
		2:       return y & b;
		3:       return y | b;
		4:       return y >> s;
		5:       return y[datapathPkg::wordWidth-1] ? ((y >> s) | ~(ones >> s)) : (y >> s);
		6:       return y << s;
		7:       return (y >> s) | (y << (datapathPkg::wordWidth - s));	// Wraps low bits up
		8:       return (y << s) | (y >> (datapathPkg::wordWidth - s));
		9:       return -b;
		10:      return ~b;
		default: return b;	// Plain pass-through
	endcase
endfunction

`endif

// File: verif/datapathTb.sv
`timescale 1ns/100ps
`default_nettype none

module datapathTb;
	import cpuIsaPkg::*;
	import datapathPkg::*;

	localparam int clkPeriod = 40;
	localparam int fetchCount = 6;
	localparam int storeRounds = 8;
	// Cycle estimates per test: reset, transfer, store/load, ALU, fetch
	localparam int totalCycles = 70 + 100 + 140 + 80 + 90;

	logic clock = 1'b0;
	logic rstN;
	logic pcOut, mdrOut, zOut, rOut, baOut, cseOut, inPortOut;
	logic pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn, outPortIn;
	logic mdMuxRead, ramRead, ramWrite, gra, grb, grc, incPc;
	logic [10:0] aluOps;	// One bit per ALU op, model order
	wire opAdd, opSub, opAnd, opOr, opShr, opShra, opShl, opRor, opRol, opNeg, opNot;
	logic [wordWidth-1:0] inPortData;
	logic [wordWidth-1:0] outPortData;
	int errorCount = 0;
	int checkCount = 0;
	int testErrors = 0;
	int testChecks = 0;

	assign {opNot, opNeg, opRol, opRor, opShl, opShra, opShr, opOr, opAnd, opSub, opAdd} = aluOps;

	`include "datapathModel.svh"

	datapath i_dut (.*);

	initial begin
		forever #(clkPeriod / 2) clock = ~clock;
	end

	// New control step, every strobe drops unless set again
	task automatic nextStep();
		@(posedge clock);
		{pcOut, mdrOut, zOut, rOut, baOut, cseOut, inPortOut} <= '0;
		{pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn, outPortIn} <= '0;
		{mdMuxRead, ramRead, ramWrite, gra, grb, grc, incPc, aluOps} <= '0;
	endtask

	// Current bus source goes to the output port, compared one cycle later
	task automatic observe(input string name, input logic [wordWidth-1:0] expected);
		outPortIn <= 1'b1;
		nextStep();
		@(negedge clock);	// Port settled after the latching edge
		testChecks++;
		if (outPortData !== expected) begin
			$display("CHECK FAILED at %0t: %s expected %h actual %h",
				$time, name, expected, outPortData);
			testErrors++;
		end
	endtask

	task automatic readField(input int sel, input logic ba, input string name,
		input logic [wordWidth-1:0] expected);
		nextStep();
		gra <= (sel == 0);
		grb <= (sel == 1);
		grc <= (sel == 2);
		rOut <= !ba;
		baOut <= ba;
		observe(name, expected);
	endtask

	task automatic finishTest(input string name);
		$display("Test %-10s %0d checks, %0d errors", name, testChecks, testErrors);
		checkCount += testChecks;
		errorCount += testErrors;
		testChecks = 0;
		testErrors = 0;
	endtask

	// Input port on the bus, the caller adds the load strobes
	task automatic driveIn(input logic [wordWidth-1:0] data);
		nextStep();
		inPortData <= data;
		inPortOut <= 1'b1;
	endtask

	task automatic loadIr(input logic [regFieldWidth-1:0] ra,
		input logic [regFieldWidth-1:0] rb, input logic [constWidth-1:0] c);
		instrWord word;
		word = '0;
		word.iFmt.ra = ra;
		word.iFmt.rb = rb;
		word.iFmt.c = c;
		driveIn(word);
		irIn <= 1'b1;
	endtask

	task automatic writeReg(input logic [regFieldWidth-1:0] idx,
		input logic [wordWidth-1:0] data);
		loadIr(idx, '0, '0);
		driveIn(data);
		gra <= 1'b1;
		rIn <= 1'b1;
		modelRegs[idx] = data;
	endtask

	task automatic readReg(input logic [regFieldWidth-1:0] idx, input logic ba);
		loadIr(idx, '0, '0);
		readField(0, ba, $sformatf("outPortData for R%0d", idx), modelReadReg(idx, ba));
	endtask

	// T3 to T5 of ld and st, MAR ends up with base plus constant
	task automatic effectiveAddress();
		nextStep();
		grb <= 1'b1;
		baOut <= 1'b1;
		yIn <= 1'b1;
		nextStep();
		cseOut <= 1'b1;
		aluOps[0] <= 1'b1;	// Add
		zIn <= 1'b1;
		nextStep();
		zOut <= 1'b1;
		marIn <= 1'b1;
	endtask

	task automatic resetTest();
		nextStep();
		pcOut <= 1'b1;
		observe("outPortData for PC", '0);
		for (int i = 0; i < regCount; i++) begin
			readReg(regFieldWidth'(i), 1'b0);
		end
		finishTest("reset");
	endtask

	task automatic transferTest();
		writeReg('0, lfsrBits(wordWidth));
		for (int i = 0; i < regCount; i++) begin
			writeReg(regFieldWidth'(lfsrBits(regFieldWidth)), lfsrBits(wordWidth));
		end
		for (int i = 0; i < regCount; i++) begin
			readReg(regFieldWidth'(i), 1'b0);
		end
		readReg('0, 1'b1);	// Base read of R0
		finishTest("transfer");
	endtask

	task automatic storeLoadTest();
		logic [regFieldWidth-1:0] src;
		logic [regFieldWidth-1:0] base;
		logic [regFieldWidth-1:0] dst;
		logic [constWidth-1:0] c;
		logic [wordWidth-1:0] addr;
		for (int i = 0; i < storeRounds; i++) begin
			src = regFieldWidth'(lfsrBits(regFieldWidth));
			base = regFieldWidth'(lfsrBits(regFieldWidth));
			dst = regFieldWidth'(lfsrBits(regFieldWidth));
			c = constWidth'(lfsrBits(constWidth));
			addr = modelReadReg(base, 1'b1) + modelSext(c);
			// st src,c(base)
			loadIr(src, base, c);
			effectiveAddress();
			nextStep();
			gra <= 1'b1;
			rOut <= 1'b1;
			mdrIn <= 1'b1;	// MDR from the bus
			nextStep();
			ramWrite <= 1'b1;
			modelRam[addr[ramAddrWidth-1:0]] = modelRegs[src];
			// ld dst,c(base)
			loadIr(dst, base, c);
			effectiveAddress();
			nextStep();
			ramRead <= 1'b1;
			mdMuxRead <= 1'b1;
			mdrIn <= 1'b1;
			nextStep();
			mdrOut <= 1'b1;
			gra <= 1'b1;
			rIn <= 1'b1;
			modelRegs[dst] = modelRam[addr[ramAddrWidth-1:0]];
			readReg(dst, 1'b0);
		end
		finishTest("store/load");
	endtask

	task automatic aluTest();
		logic [wordWidth-1:0] y;
		logic [wordWidth-1:0] b;
		logic [regFieldWidth-1:0] dst;
		for (int op = 0; op < 11; op++) begin
			y = lfsrBits(wordWidth);
			b = lfsrBits(wordWidth);
			dst = regFieldWidth'(lfsrBits(regFieldWidth));
			loadIr(dst, '0, '0);
			driveIn(y);
			yIn <= 1'b1;
			driveIn(b);
			aluOps[op] <= 1'b1;
			zIn <= 1'b1;
			nextStep();
			zOut <= 1'b1;
			gra <= 1'b1;
			rIn <= 1'b1;
			modelRegs[dst] = modelAlu(op, y, b);
			readField(0, 1'b0, $sformatf("outPortData for ALU op %0d", op), modelRegs[dst]);
		end
		finishTest("alu");
	endtask

	task automatic fetchTest();
		instrWord word;
		// Program image at addresses 0 and up
		for (int i = 0; i < fetchCount; i++) begin
			word = lfsrBits(wordWidth);
			modelRam[i] = word;
			driveIn(wordWidth'(i));
			marIn <= 1'b1;
			driveIn(word);
			mdrIn <= 1'b1;
			nextStep();
			ramWrite <= 1'b1;
		end
		driveIn('0);
		pcIn <= 1'b1;
		modelPc = '0;
		for (int i = 0; i < fetchCount; i++) begin
			nextStep();	// T0
			pcOut <= 1'b1;
			marIn <= 1'b1;
			incPc <= 1'b1;
			zIn <= 1'b1;
			nextStep();	// T1
			zOut <= 1'b1;
			pcIn <= 1'b1;
			ramRead <= 1'b1;
			mdMuxRead <= 1'b1;
			mdrIn <= 1'b1;
			nextStep();	// T2
			mdrOut <= 1'b1;
			irIn <= 1'b1;
			word = modelRam[modelPc[ramAddrWidth-1:0]];
			modelPc = modelPc + 1;
			readField(0, 1'b0, "outPortData for IR ra", modelRegs[word.rFmt.ra]);
			readField(1, 1'b0, "outPortData for IR rb", modelRegs[word.rFmt.rb]);
			readField(2, 1'b0, "outPortData for IR rc", modelRegs[word.rFmt.rc]);
		end
		nextStep();
		pcOut <= 1'b1;
		observe("outPortData for PC", modelPc);
		finishTest("fetch");
	endtask

	initial begin
		{pcOut, mdrOut, zOut, rOut, baOut, cseOut, inPortOut} = '0;
		{pcIn, irIn, marIn, mdrIn, yIn, zIn, rIn, outPortIn} = '0;
		{mdMuxRead, ramRead, ramWrite, gra, grb, grc, incPc, aluOps} = '0;
		inPortData = '0;
		rstN = 1'b0;
		modelPc = '0;
		foreach (modelRegs[i]) begin
			modelRegs[i] = '0;
		end
		repeat (10) @(posedge clock);
		rstN <= 1'b1;
		resetTest();
		transferTest();
		storeLoadTest();
		aluTest();
		fetchTest();
		$display("Totals: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(2 * totalCycles * clkPeriod);
		$display("Timeout: tests did not finish within %0d cycles", 2 * totalCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
+incdir+include
source/cpuIsaPkg.sv
source/datapathPkg.sv
source/registerFile.sv
source/aluUnit.sv
source/memorySubsystem.sv
source/datapath.sv
verif/datapathTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the datapath testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
passMsg="Simulation completed successfully"

verilator --binary --timing -Wno-fatal --top-module datapathTb -f tb.f -o datapathSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/datapathSim > "$logFile" 2>&1
runStatus=$?
cat "$logFile"
if [ $runStatus -ne 0 ]; then
	echo "Simulation run returned status $runStatus"
	exit 1
fi

if grep -q "$passMsg" "$logFile"; then
	exit 0
fi
echo "Pass message not found in $logFile"
exit 1
